// ==== src/fcpu_consts.svh ====
`ifndef FCPU_CONSTS_SVH
`define FCPU_CONSTS_SVH

// ====================
// Datapath widths
// ====================
`define DATA_W      32
`define TAG_W       3     // Top bit selects the producing unit
`define OPC_W       4
`define N_STATIONS  4

// ====================
// ALU opcodes
// ====================
`define OPC_SL      4'd0
`define OPC_SRL     4'd1
`define OPC_SRA     4'd2
`define OPC_ADD     4'd3
`define OPC_ADDI    4'd4
`define OPC_SUB     4'd5
`define OPC_SUBI    4'd6
`define OPC_SAVE    4'd7
`define OPC_AND     4'd8
`define OPC_OR      4'd9
`define OPC_XOR     4'd10
`define OPC_SETI1   4'd11
`define OPC_SETI2   4'd12
`define OPC_NOP     4'd15

`endif

// ==== src/fcpu_pkg.sv ====
`include "fcpu_consts.svh"

package fcpu_pkg;

   typedef logic [`DATA_W-1:0] data_t;
   typedef logic [`TAG_W-1:0]  tag_t;   // MSB 0 for ALU, 1 for load unit

   typedef enum logic [`OPC_W-1:0] {
      SL    = `OPC_SL,
      SRL   = `OPC_SRL,
      SRA   = `OPC_SRA,
      ADD   = `OPC_ADD,
      ADDI  = `OPC_ADDI,
      SUB   = `OPC_SUB,
      SUBI  = `OPC_SUBI,
      SAVE  = `OPC_SAVE,
      AND   = `OPC_AND,
      OR    = `OPC_OR,
      XOR   = `OPC_XOR,
      SETI1 = `OPC_SETI1,
      SETI2 = `OPC_SETI2,
      NOP   = `OPC_NOP
   } opcode_e;

   // Either a value or the tag of its producer
   typedef struct packed {
      logic  filled;
      tag_t  tag;
      data_t data;
   } operand_t;

   typedef struct packed {
      tag_t     dest;
      opcode_e  opcode;
      operand_t a;
      operand_t b;
   } dispatch_t;

   // Resolved instruction as handed to the ALU
   typedef struct packed {
      tag_t    dest;
      opcode_e opcode;
      data_t   a;
      data_t   b;
   } calc_t;

   typedef struct packed {
      tag_t  tag;
      data_t data;
   } cdb_t;

endpackage

// ==== src/reservation_station.sv ====
`timescale 1ns/1ps
`include "fcpu_consts.svh"

module reservation_station #(
   parameter int N_STATIONS = `N_STATIONS
) (
   input  logic                clk,
   input  logic                nrst,

   input  logic                i_valid,
   input  fcpu_pkg::dispatch_t i_data,
   output logic                o_ready,

   output logic                o_issue_valid,
   output fcpu_pkg::calc_t     o_issue,
   input  logic                i_issue_ready,

   input  logic                i_cdb_valid,
   input  fcpu_pkg::cdb_t      i_cdb
);

   localparam int IDX_W = (N_STATIONS > 1) ? $clog2(N_STATIONS) : 1;

   logic [N_STATIONS-1:0] busy;
   logic [N_STATIONS-1:0] eligible;
   logic [IDX_W-1:0]      age [N_STATIONS];   // 0 is the youngest
   fcpu_pkg::dispatch_t   entry [N_STATIONS];
   fcpu_pkg::dispatch_t   new_entry;

   logic                  free_found;
   logic [IDX_W-1:0]      free_idx;
   logic                  sel_found;
   logic [IDX_W-1:0]      sel_idx;
   logic [IDX_W-1:0]      sel_age;
   logic                  accept;
   logic                  issue_fire;

   // Fill a waiting operand from a matching CDB broadcast
   function automatic fcpu_pkg::operand_t snoop(input fcpu_pkg::operand_t op,
                                                input logic               cdb_valid,
                                                input fcpu_pkg::cdb_t     cdb);
      fcpu_pkg::operand_t res;
      res = op;
      if (!op.filled && cdb_valid && (op.tag == cdb.tag)) begin
         res.filled = 1'b1;
         res.data   = cdb.data;
      end
      return res;
   endfunction

   // ====================
   // Allocation
   // ====================
   always_comb begin
      free_found = 1'b0;
      free_idx   = '0;
      for (int i = 0; i < N_STATIONS; i++) begin
         if (!busy[i] && !free_found) begin
            free_found = 1'b1;
            free_idx   = IDX_W'(i);
         end
      end
   end

   assign o_ready = free_found;
   assign accept  = i_valid && o_ready;

   // Same-cycle capture for the entry being written
   always_comb begin
      new_entry   = i_data;
      new_entry.a = snoop(i_data.a, i_cdb_valid, i_cdb);
      new_entry.b = snoop(i_data.b, i_cdb_valid, i_cdb);
   end

   // ====================
   // Oldest-ready select
   // ====================
   always_comb begin
      sel_found = 1'b0;
      sel_idx   = '0;
      sel_age   = '0;
      for (int i = 0; i < N_STATIONS; i++) begin
         eligible[i] = busy[i] && entry[i].a.filled && entry[i].b.filled;
         if (eligible[i] && (!sel_found || (age[i] > sel_age))) begin
            sel_found = 1'b1;
            sel_idx   = IDX_W'(i);
            sel_age   = age[i];
         end
      end
   end

   assign o_issue_valid  = sel_found;
   assign o_issue.dest   = entry[sel_idx].dest;
   assign o_issue.opcode = entry[sel_idx].opcode;
   assign o_issue.a      = entry[sel_idx].a.data;
   assign o_issue.b      = entry[sel_idx].b.data;
   assign issue_fire     = sel_found && i_issue_ready;

   // Ages stay dense: accept bumps everyone, issue closes the gap
   always_ff @(posedge clk) begin
      if (nrst) begin
         busy <= '0;
         for (int i = 0; i < N_STATIONS; i++) begin
            age[i] <= '0;
         end
      end else begin
         for (int i = 0; i < N_STATIONS; i++) begin
            if (accept && (free_idx == IDX_W'(i))) begin
               busy[i] <= 1'b1;
               age[i]  <= '0;
            end else if (issue_fire && (sel_idx == IDX_W'(i))) begin
               busy[i] <= 1'b0;
            end else if (busy[i]) begin
               if (accept && !(issue_fire && (age[i] > sel_age))) begin
                  age[i] <= age[i] + 1'b1;
               end else if (!accept && issue_fire && (age[i] > sel_age)) begin
                  age[i] <= age[i] - 1'b1;
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < N_STATIONS; i++) begin
         if (accept && (free_idx == IDX_W'(i))) begin
            entry[i] <= new_entry;
         end else begin
            entry[i].a <= snoop(entry[i].a, i_cdb_valid, i_cdb);
            entry[i].b <= snoop(entry[i].b, i_cdb_valid, i_cdb);
         end
      end
   end

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps
`include "fcpu_consts.svh"

module alu (
   input  logic                clk,
   input  logic                nrst,

   input  logic                i_valid,
   input  fcpu_pkg::dispatch_t i_data,
   output logic                o_ready,

   input  logic                i_cdb_valid,
   input  fcpu_pkg::cdb_t      i_cdb,

   output logic                o_valid,
   output fcpu_pkg::cdb_t      o_result,
   input  logic                i_ready
);

   localparam int SHAMT_W = $clog2(`DATA_W);
   localparam int HALF_W  = `DATA_W / 2;

   logic               issue_valid;
   fcpu_pkg::calc_t    issue;
   logic               calc_ready;
   logic               calc_valid;
   fcpu_pkg::calc_t    calc;
   logic [SHAMT_W-1:0] shamt;
   fcpu_pkg::data_t    result;

   reservation_station #(
      .N_STATIONS(`N_STATIONS)
   ) u_rs (
      .clk           (clk),
      .nrst          (nrst),
      .i_valid       (i_valid),
      .i_data        (i_data),
      .o_ready       (o_ready),
      .o_issue_valid (issue_valid),
      .o_issue       (issue),
      .i_issue_ready (calc_ready),
      .i_cdb_valid   (i_cdb_valid),
      .i_cdb         (i_cdb)
   );

   assign calc_ready = !calc_valid || i_ready;   // Empty or draining

   always_ff @(posedge clk) begin
      if (nrst) begin
         calc_valid <= 1'b0;
      end else if (calc_ready) begin
         calc_valid <= issue_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (calc_ready && issue_valid) begin
         calc <= issue;
      end
   end

   // ====================
   // Result
   // ====================
   assign shamt = calc.b[SHAMT_W-1:0];

   always_comb begin
      case (calc.opcode)
         fcpu_pkg::SL:                 result = calc.a << shamt;
         fcpu_pkg::SRL:                result = calc.a >> shamt;
         fcpu_pkg::SRA:                result = $signed(calc.a) >>> shamt;
         fcpu_pkg::ADD, fcpu_pkg::ADDI: result = calc.a + calc.b;
         fcpu_pkg::SUB, fcpu_pkg::SUBI: result = calc.a - calc.b;
         fcpu_pkg::SAVE:               result = calc.a + `DATA_W'd2;
         fcpu_pkg::AND:                result = calc.a & calc.b;
         fcpu_pkg::OR:                 result = calc.a | calc.b;
         fcpu_pkg::XOR:                result = calc.a ^ calc.b;
         fcpu_pkg::SETI1:              result = {{HALF_W{1'b0}}, calc.b[HALF_W-1:0]};
         fcpu_pkg::SETI2:              result = {calc.b[HALF_W-1:0], calc.a[HALF_W-1:0]};
         default:                      result = '0;   // NOP
      endcase
   end

   assign o_valid       = calc_valid;
   assign o_result.tag  = calc.dest;
   assign o_result.data = result;

endmodule

// ==== src/cdb_arbiter.sv ====
`timescale 1ns/1ps

module cdb_arbiter (
   input  logic           clk,
   input  logic           nrst,

   input  logic           i_alu_valid,
   input  fcpu_pkg::cdb_t i_alu,
   output logic           o_alu_ready,

   input  logic           i_ext_valid,
   input  fcpu_pkg::cdb_t i_ext,
   output logic           o_ext_ready,

   output logic           o_cdb_valid,
   output fcpu_pkg::cdb_t o_cdb
);

   logic last_alu;   // ALU won the previous grant
   logic grant_alu;
   logic grant_ext;

   // ====================
   // Round-robin grant
   // ====================
   // Under contention the side that lost last time goes first
   always_comb begin
      grant_alu = 1'b0;
      grant_ext = 1'b0;
      if (i_alu_valid && i_ext_valid) begin
         grant_alu = !last_alu;
         grant_ext = last_alu;
      end else begin
         grant_alu = i_alu_valid;
         grant_ext = i_ext_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         last_alu <= 1'b0;
      end else if (grant_alu) begin
         last_alu <= 1'b1;
      end else if (grant_ext) begin
         last_alu <= 1'b0;
      end
   end

   assign o_alu_ready = grant_alu;
   assign o_ext_ready = grant_ext;

   // Broadcast the winner, no back-pressure past here
   assign o_cdb_valid = grant_alu || grant_ext;
   assign o_cdb       = grant_ext ? i_ext : i_alu;

endmodule

// ==== src/exec_cluster.sv ====
`timescale 1ns/1ps

module exec_cluster (
   input  logic                clk,
   input  logic                nrst,

   input  logic                i_disp_valid,
   input  fcpu_pkg::dispatch_t i_disp,
   output logic                o_disp_ready,

   input  logic                i_ext_valid,
   input  fcpu_pkg::cdb_t      i_ext,
   output logic                o_ext_ready,

   output logic                o_cdb_valid,
   output fcpu_pkg::cdb_t      o_cdb
);

   logic           alu_valid;
   fcpu_pkg::cdb_t alu_result;
   logic           alu_ready;
   logic           cdb_valid;
   fcpu_pkg::cdb_t cdb;

   alu u_alu (
      .clk         (clk),
      .nrst        (nrst),
      .i_valid     (i_disp_valid),
      .i_data      (i_disp),
      .o_ready     (o_disp_ready),
      .i_cdb_valid (cdb_valid),   // CDB loops back for operand capture
      .i_cdb       (cdb),
      .o_valid     (alu_valid),
      .o_result    (alu_result),
      .i_ready     (alu_ready)
   );

   cdb_arbiter u_arb (
      .clk         (clk),
      .nrst        (nrst),
      .i_alu_valid (alu_valid),
      .i_alu       (alu_result),
      .o_alu_ready (alu_ready),
      .i_ext_valid (i_ext_valid),
      .i_ext       (i_ext),
      .o_ext_ready (o_ext_ready),
      .o_cdb_valid (cdb_valid),
      .o_cdb       (cdb)
   );

   assign o_cdb_valid = cdb_valid;
   assign o_cdb       = cdb;

endmodule

// ==== testbench/exec_cluster_props.sv ====
`timescale 1ns/1ps

module exec_cluster_props (
   input logic           clk,
   input logic           nrst,
   input logic           o_disp_ready,
   input logic           o_cdb_valid,
   input logic           alu_valid,
   input logic           alu_ready,
   input fcpu_pkg::cdb_t alu_result,
   input logic           o_ext_ready,
   input logic           rs_issue_fire
);

   // ====================
   // Reset
   // ====================
   a_cdb_idle_in_reset: assert property (@(posedge clk) nrst |=> !o_cdb_valid)
      else $error("CDB valid seen right after a reset cycle");

   // ====================
   // Arbitration
   // ====================
   // A waiting ALU result must not change under the arbiter
   a_alu_hold: assert property (@(posedge clk) disable iff (nrst)
      alu_valid && !alu_ready |=> alu_valid && $stable(alu_result))
      else $error("ALU result changed while it was not granted");

   a_one_grant: assert property (@(posedge clk) disable iff (nrst)
      !(alu_ready && o_ext_ready))
      else $error("ALU and external result granted in the same cycle");

   // ====================
   // Dispatch
   // ====================
   // A full station stays full until one of its entries issues
   a_full_until_issue: assert property (@(posedge clk) disable iff (nrst)
      !o_disp_ready && !rs_issue_fire |=> !o_disp_ready)
      else $error("Station freed an entry without issuing it");

endmodule

bind exec_cluster exec_cluster_props u_props (
   .clk           (clk),
   .nrst          (nrst),
   .o_disp_ready  (o_disp_ready),
   .o_cdb_valid   (o_cdb_valid),
   .alu_valid     (alu_valid),
   .alu_ready     (alu_ready),
   .alu_result    (alu_result),
   .o_ext_ready   (o_ext_ready),
   .rs_issue_fire (u_alu.u_rs.issue_fire)
);

// ==== testbench/tb_exec_cluster.sv ====
`timescale 1ns/1ps

module tb_exec_cluster;

   typedef struct {
      string               name;
      logic                do_disp;
      fcpu_pkg::dispatch_t disp;
      logic                do_ext;
      fcpu_pkg::cdb_t      ext;
      logic                stall;   // Random idle cycles before the external result
      logic                drain;   // Wait for all earlier rows first
      int                  after;   // Row that must complete before this one
   } test_t;

   logic                clk;
   logic                nrst;
   logic                i_disp_valid;
   fcpu_pkg::dispatch_t i_disp;
   logic                o_disp_ready;
   logic                i_ext_valid;
   fcpu_pkg::cdb_t      i_ext;
   logic                o_ext_ready;
   logic                o_cdb_valid;
   fcpu_pkg::cdb_t      o_cdb;

   test_t           tests[$];
   bit              done[];
   int              alu_pend[8][$];   // Scoreboard keyed by destination tag
   int              ext_sent[$];
   int              ext_todo[$];
   fcpu_pkg::data_t tag_val[8];
   int              n_pass = 0;
   int              n_fail = 0;
   int              cycles = 0;
   int              limit = 0;
   bit              running = 0;
   bit              bp_seen = 0;
   bit              prev_contend = 0;
   bit              prev_alu_won = 0;

   exec_cluster u_exec_cluster (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic fcpu_pkg::operand_t val(input fcpu_pkg::data_t d);
      return '{filled: 1'b1, tag: '0, data: d};
   endfunction

   function automatic fcpu_pkg::operand_t wait_on(input fcpu_pkg::tag_t t);
      return '{filled: 1'b0, tag: t, data: '0};
   endfunction

   // Result rule applied to resolved operands
   function automatic fcpu_pkg::data_t apply_rule(input fcpu_pkg::opcode_e op,
                                                  input fcpu_pkg::data_t a,
                                                  input fcpu_pkg::data_t b);
      case (op)
         fcpu_pkg::SL:                   return a << b[4:0];
         fcpu_pkg::SRL:                  return a >> b[4:0];
         fcpu_pkg::SRA:                  return fcpu_pkg::data_t'($signed(a) >>> b[4:0]);
         fcpu_pkg::ADD, fcpu_pkg::ADDI:  return a + b;
         fcpu_pkg::SUB, fcpu_pkg::SUBI:  return a - b;
         fcpu_pkg::SAVE:                 return a + 32'd2;
         fcpu_pkg::AND:                  return a & b;
         fcpu_pkg::OR:                   return a | b;
         fcpu_pkg::XOR:                  return a ^ b;
         fcpu_pkg::SETI1:                return {16'h0000, b[15:0]};
         fcpu_pkg::SETI2:                return {b[15:0], a[15:0]};
         default:                        return '0;
      endcase
   endfunction

   function automatic fcpu_pkg::data_t resolve(input fcpu_pkg::operand_t op);
      return op.filled ? op.data : tag_val[op.tag];
   endfunction

   task automatic disp_row(input string name, input fcpu_pkg::tag_t dest,
                           input fcpu_pkg::opcode_e op, input fcpu_pkg::operand_t a,
                           input fcpu_pkg::operand_t b, input logic drain, input int after);
      test_t t;
      t.name = name;
      t.do_disp = 1'b1;
      t.disp = '{dest: dest, opcode: op, a: a, b: b};
      t.do_ext = 1'b0;
      t.ext = '0;
      t.stall = 1'b0;
      t.drain = drain;
      t.after = after;
      tests.push_back(t);
   endtask

   task automatic ext_row(input string name, input fcpu_pkg::tag_t tag,
                          input fcpu_pkg::data_t d, input logic stall, input logic drain);
      test_t t;
      t.name = name;
      t.do_disp = 1'b0;
      t.disp = '0;
      t.do_ext = 1'b1;
      t.ext = '{tag: tag, data: d};
      t.stall = stall;
      t.drain = drain;
      t.after = -1;
      tests.push_back(t);
   endtask

   // ====================
   // Stimulus table
   // ====================
   task automatic build_table();
      int k;
      disp_row("sl", 0, fcpu_pkg::SL, val(32'h0000_00f1), val(32'd36), 0, -1);
      disp_row("srl", 1, fcpu_pkg::SRL, val(32'h8000_0010), val(32'd4), 0, -1);
      disp_row("sra_neg", 2, fcpu_pkg::SRA, val(32'hf000_0100), val(32'd8), 0, -1);
      disp_row("add", 3, fcpu_pkg::ADD, val(32'd1234), val(32'd4321), 0, -1);
      disp_row("addi", 0, fcpu_pkg::ADDI, val(32'hffff_fff0), val(32'd32), 0, -1);
      disp_row("sub", 1, fcpu_pkg::SUB, val(32'd500), val(32'd123), 0, -1);
      disp_row("subi_wrap", 2, fcpu_pkg::SUBI, val(32'd1), val(32'd5), 0, -1);
      disp_row("save", 3, fcpu_pkg::SAVE, val(32'h0000_1000), val(32'd99), 0, -1);
      disp_row("and", 0, fcpu_pkg::AND, val(32'hf0f0_ff00), val(32'h3c3c_0ff0), 0, -1);
      disp_row("or", 1, fcpu_pkg::OR, val(32'h1200_0034), val(32'h0056_7800), 0, -1);
      disp_row("xor", 2, fcpu_pkg::XOR, val(32'haaaa_5555), val(32'hffff_0000), 0, -1);
      disp_row("seti1", 3, fcpu_pkg::SETI1, val(32'hdead_beef), val(32'h1234_abcd), 0, -1);
      disp_row("seti2", 0, fcpu_pkg::SETI2, val(32'hcafe_5678), val(32'h9999_1234), 0, -1);
      disp_row("nop", 1, fcpu_pkg::NOP, val(32'd7), val(32'd9), 0, -1);
      // Dependent operands
      disp_row("dep_src", 0, fcpu_pkg::ADD, val(32'd10), val(32'd20), 1, -1);
      disp_row("dep_alu", 1, fcpu_pkg::ADD, wait_on(0), val(32'd5), 0, -1);
      disp_row("dep_ext", 2, fcpu_pkg::SUB, wait_on(4), wait_on(1), 0, -1);
      ext_row("ext_100", 4, 32'd100, 1, 0);
      // Waiting entry bypassed by later ready ones
      disp_row("ooo_wait", 3, fcpu_pkg::ADD, wait_on(5), val(32'd1), 1, tests.size() + 2);
      disp_row("ooo_xor", 0, fcpu_pkg::XOR, val(32'h0f0f_0f0f), val(32'h00ff_00ff), 0, -1);
      disp_row("ooo_or", 1, fcpu_pkg::OR, val(32'h0000_0011), val(32'h0000_2200), 0, -1);
      ext_row("ooo_ext", 5, 32'd7, 1, 0);
      // Contention on the CDB
      ext_row("arb_ext6", 6, 32'h6666_0006, 0, 1);
      disp_row("arb_and", 2, fcpu_pkg::AND, val(32'hffff_ffff), val(32'h0bad_f00d), 0, -1);
      ext_row("arb_ext7", 7, 32'h7777_0007, 0, 0);
      disp_row("arb_add", 3, fcpu_pkg::ADD, val(32'd3), val(32'd4), 0, -1);
      // Back-pressure, the first four wait on the last external result
      for (k = 0; k < 8; k++) begin
         ext_row($sformatf("bp_busy%0d", k), fcpu_pkg::tag_t'(4 + k % 3), 32'h100 + k, 0, k == 0);
      end
      ext_row("bp_key", 7, 32'h0000_0040, 1, 0);
      for (k = 0; k < 5; k++) begin
         disp_row($sformatf("bp_op%0d", k), fcpu_pkg::tag_t'(k % 4), fcpu_pkg::ADD,
                  (k < 4) ? wait_on(7) : val(32'h0000_0040), val(k), 0, -1);
      end
   endtask

   // ====================
   // Compare tasks
   // ====================
   task automatic check_cdb(input string name, input fcpu_pkg::cdb_t expected,
                            input fcpu_pkg::cdb_t actual);
      if (expected === actual) begin
         n_pass++;
         $display("[PASS] %s tag=%0d data=%h", name, actual.tag, actual.data);
      end else begin
         n_fail++;
         $display("[FAIL] %s expected tag=%0d data=%h actual tag=%0d data=%h",
                  name, expected.tag, expected.data, actual.tag, actual.data);
      end
   endtask

   task automatic check_flag(input string name, input logic expected, input logic actual);
      if (expected === actual) begin
         n_pass++;
         $display("[PASS] %s", name);
      end else begin
         n_fail++;
         $display("[FAIL] %s expected %b actual %b", name, expected, actual);
      end
   endtask

   function automatic bit rows_done(input int upto);
      for (int i = 0; i < upto; i++) begin
         if (!done[i]) return 0;
      end
      return 1;
   endfunction

   // ====================
   // CDB monitor
   // ====================
   always @(negedge clk) begin
      int idx;
      fcpu_pkg::cdb_t exp;
      bit contend;
      if (running) begin
         if (!o_disp_ready) bp_seen = 1;
         contend = u_exec_cluster.alu_valid && i_ext_valid;
         if (contend && prev_contend && (u_exec_cluster.alu_ready == prev_alu_won)) begin
            n_fail++;
            $display("Arbiter granted the same side twice in a row under contention");
         end
         prev_contend = contend;
         prev_alu_won = u_exec_cluster.alu_ready;
         if (o_cdb_valid && o_cdb.tag[2]) begin
            if (ext_sent.size() == 0) begin
               n_fail++;
               $display("External result on the CDB that was never sent, tag %0d", o_cdb.tag);
            end else begin
               idx = ext_sent.pop_front();
               check_cdb(tests[idx].name, tests[idx].ext, o_cdb);
               done[idx] = 1;
            end
         end else if (o_cdb_valid) begin
            if (alu_pend[o_cdb.tag].size() == 0) begin
               n_fail++;
               $display("ALU result on the CDB with no dispatch pending, tag %0d", o_cdb.tag);
            end else begin
               idx = alu_pend[o_cdb.tag].pop_front();
               exp.tag = tests[idx].disp.dest;
               exp.data = apply_rule(tests[idx].disp.opcode, resolve(tests[idx].disp.a),
                                     resolve(tests[idx].disp.b));
               if (tests[idx].after >= 0 && !done[tests[idx].after]) begin
                  n_fail++;
                  $display("%s completed before %s", tests[idx].name,
                           tests[tests[idx].after].name);
               end
               check_cdb(tests[idx].name, exp, o_cdb);
               done[idx] = 1;
            end
         end
         if (o_cdb_valid) tag_val[o_cdb.tag] = o_cdb.data;
      end
   end

   // Watchdog
   always @(posedge clk) begin
      if (running) begin
         cycles++;
         if (cycles >= limit) begin
            $display("Timeout after %0d cycles, results never seen:", cycles);
            foreach (done[i]) begin
               if (!done[i]) $display("  %s (tag %0d)", tests[i].name,
                                      tests[i].do_ext ? tests[i].ext.tag : tests[i].disp.dest);
            end
            $display(">>> FAIL");
            $finish;
         end
      end
   end

   // External result driver
   initial begin
      int idx;
      while (!running) @(posedge clk);
      #5;
      forever begin
         if (ext_todo.size() == 0) begin
            @(negedge clk);   // New rows are picked up at the falling edge
            if (ext_todo.size() != 0) begin
               @(posedge clk);
               #5;
            end
         end else begin
            idx = ext_todo.pop_front();
            if (tests[idx].stall) begin
               repeat ($urandom_range(3, 0)) begin
                  @(posedge clk);
                  #5;
               end
            end
            i_ext_valid = 1'b1;
            i_ext = tests[idx].ext;
            ext_sent.push_back(idx);
            @(negedge clk);
            while (!o_ext_ready) @(negedge clk);
            @(posedge clk);
            #5;
            i_ext_valid = 1'b0;
         end
      end
   end

   initial begin
      void'($urandom(22762));
      nrst = 1'b1;
      i_disp_valid = 1'b0;
      i_disp = '0;
      i_ext_valid = 1'b0;
      i_ext = '0;
      foreach (tag_val[i]) tag_val[i] = '0;
      build_table();
      done = new[tests.size()];
      limit = tests.size() * 20;
      repeat (5) @(posedge clk);
      #5;
      nrst = 1'b0;
      running = 1;
      foreach (tests[i]) begin
         if (tests[i].drain) begin
            while (!rows_done(i)) begin
               @(posedge clk);
               #5;
            end
         end
         if (tests[i].do_ext) ext_todo.push_back(i);
         if (tests[i].do_disp) begin
            alu_pend[tests[i].disp.dest].push_back(i);
            i_disp_valid = 1'b1;
            i_disp = tests[i].disp;
            @(negedge clk);
            while (!o_disp_ready) @(negedge clk);
            @(posedge clk);
            #5;
            i_disp_valid = 1'b0;
         end
      end
      while (!rows_done(tests.size())) begin
         @(posedge clk);
         #5;
      end
      check_flag("backpressure", 1'b1, bp_seen);
      $display("Checks passed: %0d, failed: %0d", n_pass, n_fail);
      if (n_fail == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// ==== sources.f ====
+incdir+src
src/fcpu_pkg.sv
src/reservation_station.sv
src/alu.sv
src/cdb_arbiter.sv
src/exec_cluster.sv
testbench/exec_cluster_props.sv
testbench/tb_exec_cluster.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the exec_cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing \
   --top-module tb_exec_cluster \
   -f sources.f \
   -o sim_tb_exec_cluster
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/sim_tb_exec_cluster > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
   exit 0
else
   echo "Pass line not found in sim.log"
   exit 1
fi
